//--- include/rosc_defines.svh
// Build-time constants of the entropy source, included by RTL and testbench
`ifndef ROSC_DEFINES_SVH
`define ROSC_DEFINES_SVH

// ------------------------------------------------------------
// Oscillator bank
// ------------------------------------------------------------

// Toggle flops per group
// Two groups, so the bank holds twice this many
`define ROSC_NUM_OSC 16

// ------------------------------------------------------------
// Sampler
// ------------------------------------------------------------

// Cycles between the two samples of one round, 16-bit word
// Each sample phase lasts this plus one cycle
// A full round is twice this plus three cycles
`define ROSC_SAMPLE_RATE 16'h1000

// ------------------------------------------------------------
// Register map, 8-bit Wishbone addresses
// ------------------------------------------------------------

// Status word, ready flag and kept-bit count
`define ROSC_ADDR_STATUS 8'h09

// Entropy word, a read clears the ready flag
`define ROSC_ADDR_ENTROPY 8'h20

`endif

//--- source/rosc_wb_pkg.sv
// Wishbone classic bus types shared by the register block, top level and testbench
`default_nettype none

package rosc_wb_pkg;

  // ------------------------------------------------------------
  // Master to slave
  // ------------------------------------------------------------

  // Held steady by the master until ack
  typedef struct packed {
    // Bus cycle in progress
    logic        cyc;
    // Strobe for this transfer
    logic        stb;
    // Write when set, read otherwise
    logic        we;
    // Byte-wide register address
    logic [7:0]  adr;
    // Write data
    logic [31:0] dat;
  } wb_req_t;

  // ------------------------------------------------------------
  // Slave to master
  // ------------------------------------------------------------

  typedef struct packed {
    // Single-cycle acknowledge
    logic        ack;
    // Read data, valid with ack
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- source/rosc_entropy_pkg.sv
// Entropy path types shared by the oscillator bank, sampler and register block
`default_nettype none

package rosc_entropy_pkg;

  // Sampler phases, one round is sample1, sample2, decide
  typedef enum logic [1:0] {
    state_sample1 = 2'd0,
    state_sample2 = 2'd1,
    state_decide  = 2'd2
  } rosc_state_e;

  // Group parities from the oscillator bank
  typedef struct packed {
    logic f;
    logic g;
  } osc_parity_t;

  // Sampler result as seen by the register block
  typedef struct packed {
    // Kept bits, newest in bit 0
    logic [31:0] entropy;
    // Set on each 32nd kept bit
    logic        data_ready;
    // Kept bits since the last wrap
    logic [4:0]  bit_count;
  } sampler_out_t;

  // Read word, one 32-bit value seen two ways
  typedef union packed {
    // Whole word, used for the entropy register
    logic [31:0] raw;
    // Status register layout
    struct packed {
      logic [25:0] reserved;
      logic [4:0]  bit_count;
      logic        ready;
    } status;
  } rd_word_u;

endpackage

`default_nettype wire

//--- source/rosc_osc_bank.sv
// Clocked jitter model of the two ring oscillator groups, instantiated once by the top
`timescale 1ns/10ps
`default_nettype none
`include "rosc_defines.svh"

module rosc_osc_bank
  import rosc_entropy_pkg::*;
(
  input  wire         clk,
  input  wire         cycle_ctr_rst,
  output osc_parity_t parity
);

  // ------------------------------------------------------------
  // Free-running LFSR
  // ------------------------------------------------------------

  // Taps 32, 22, 2, 1 for a maximal length sequence
  logic [31:0] lfsr;
  logic        lfsr_fb;

  assign lfsr_fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

  always_ff @(posedge clk) begin
    if (cycle_ctr_rst) begin
      // Any nonzero seed works
      lfsr <= 32'hace1_2d5b;
    end else begin
      lfsr <= {lfsr[30:0], lfsr_fb};
    end
  end

  // ------------------------------------------------------------
  // Toggle flop banks
  // ------------------------------------------------------------

  // One flop per oscillator, each enabled by its own tap
  logic [`ROSC_NUM_OSC-1:0] osc_f;
  logic [`ROSC_NUM_OSC-1:0] osc_g;

  always_ff @(posedge clk) begin
    if (cycle_ctr_rst) begin
      osc_f <= '0;
      osc_g <= '0;
    end else begin
      // Group f on the low taps, group g on the taps above
      osc_f <= osc_f ^ lfsr[`ROSC_NUM_OSC-1:0];
      osc_g <= osc_g ^ lfsr[2*`ROSC_NUM_OSC-1:`ROSC_NUM_OSC];
    end
  end

  // Group parity, as the XOR of the inverter outputs in hardware
  assign parity = '{f: ^osc_f, g: ^osc_g};

endmodule

`default_nettype wire

//--- source/rosc_sampler.sv
// Double-sampling debias stage that builds 32-bit entropy words, driven by the oscillator bank
`timescale 1ns/10ps
`default_nettype none
`include "rosc_defines.svh"

module rosc_sampler
  import rosc_entropy_pkg::*;
(
  input  wire              clk,
  input  wire              cycle_ctr_rst,
  input  wire osc_parity_t parity,
  input  wire              entropy_taken,
  output sampler_out_t     result
);

  // ------------------------------------------------------------
  // Declarations
  // ------------------------------------------------------------

  // Sample period counter
  logic [15:0] cycle_ctr;
  logic        cycle_ctr_done;
  logic        cycle_ctr_clr;

  // Round FSM
  rosc_state_e state;
  rosc_state_e state_next;

  // Two samples per group, older one in bit 1
  logic [1:0]  sample_f;
  logic [1:0]  sample_g;
  logic        sample_shift;

  // Debias result of the decide cycle
  logic        keep_bit;
  logic        new_bit;

  // Output word, count and flag
  logic [31:0] entropy;
  logic [4:0]  bit_count;
  logic        data_ready;
  logic        ready_set;

  // ------------------------------------------------------------
  // Period counter and FSM
  // ------------------------------------------------------------

  assign cycle_ctr_done = (cycle_ctr == `ROSC_SAMPLE_RATE);
  // Held at zero through decide so each sample phase gets rate+1 cycles
  assign cycle_ctr_clr  = cycle_ctr_done || (state == state_decide);
  assign sample_shift   = cycle_ctr_done &&
                          ((state == state_sample1) || (state == state_sample2));

  always_comb begin
    state_next = state;
    case (state)
      state_sample1: if (cycle_ctr_done) state_next = state_sample2;
      state_sample2: if (cycle_ctr_done) state_next = state_decide;
      state_decide:  state_next = state_sample1;
      // Unused encoding, restart the round
      default:       state_next = state_sample1;
    endcase
  end

  // ------------------------------------------------------------
  // Debias
  // ------------------------------------------------------------

  // Keep only when the two sample pairs disagree
  assign keep_bit  = (state == state_decide) && ((^sample_f) != (^sample_g));
  assign new_bit   = ^sample_g;
  // 32nd kept bit, bit_count wraps on the same edge
  assign ready_set = keep_bit && (bit_count == 5'd31);

  // Both groups sampled at the end of each sample phase
  always_ff @(posedge clk) begin
    if (sample_shift) begin
      sample_f <= {sample_f[0], parity.f};
      sample_g <= {sample_g[0], parity.g};
    end
  end

  always_ff @(posedge clk) begin
    if (cycle_ctr_rst) begin
      cycle_ctr  <= '0;
      state      <= state_sample1;
      entropy    <= '0;
      bit_count  <= '0;
      data_ready <= 1'b0;
    end else begin
      cycle_ctr <= cycle_ctr_clr ? 16'd0 : cycle_ctr + 16'd1;
      state     <= state_next;
      // Unread words keep shifting, no back-pressure
      if (keep_bit) begin
        entropy   <= {entropy[30:0], new_bit};
        bit_count <= bit_count + 5'd1;
      end
      // Set wins over a clear in the same cycle
      if (ready_set) begin
        data_ready <= 1'b1;
      end else if (entropy_taken) begin
        data_ready <= 1'b0;
      end
    end
  end

  assign result = '{entropy: entropy, data_ready: data_ready, bit_count: bit_count};

endmodule

`default_nettype wire

//--- source/rosc_wb_regs.sv
// Wishbone classic register block giving status and entropy reads, instantiated by the top
`timescale 1ns/10ps
`default_nettype none
`include "rosc_defines.svh"

module rosc_wb_regs
  import rosc_wb_pkg::*;
  import rosc_entropy_pkg::*;
(
  input  wire               clk,
  input  wire               cycle_ctr_rst,
  input  wire wb_req_t      wb_req,
  output wb_rsp_t           wb_rsp,
  input  wire sampler_out_t result,
  output logic              entropy_taken
);

  // ------------------------------------------------------------
  // Access detect
  // ------------------------------------------------------------

  logic        ack_q;
  logic        bus_access;
  logic        entropy_rd;
  logic [31:0] rd_data_q;
  rd_word_u    rd_word;

  // New access only while ack is low, so ack lasts one cycle
  assign bus_access = wb_req.cyc && wb_req.stb && !ack_q;
  assign entropy_rd = bus_access && !wb_req.we && (wb_req.adr == `ROSC_ADDR_ENTROPY);

  // ------------------------------------------------------------
  // Read decode
  // ------------------------------------------------------------

  always_comb begin
    rd_word.raw = '0;
    // Writes return zero and are dropped
    if (!wb_req.we) begin
      case (wb_req.adr)
        `ROSC_ADDR_STATUS: begin
          rd_word.status.reserved  = '0;
          rd_word.status.bit_count = result.bit_count;
          rd_word.status.ready     = result.data_ready;
        end
        `ROSC_ADDR_ENTROPY: rd_word.raw = result.entropy;
        default: rd_word.raw = '0;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Response registers
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (cycle_ctr_rst) begin
      ack_q         <= 1'b0;
      entropy_taken <= 1'b0;
    end else begin
      ack_q         <= bus_access;
      // Lines up with the ack of the entropy read
      entropy_taken <= entropy_rd;
    end
  end

  // Read word captured as the access starts, presented with ack
  always_ff @(posedge clk) begin
    if (bus_access) begin
      rd_data_q <= rd_word.raw;
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rd_data_q};

endmodule

`default_nettype wire

//--- source/rosc_entropy_top.sv
// Top level of the ring oscillator entropy source, the DUT of the testbench
`timescale 1ns/10ps
`default_nettype none

module rosc_entropy_top
  import rosc_wb_pkg::*;
  import rosc_entropy_pkg::*;
(
  input  wire          clk,
  input  wire          cycle_ctr_rst,
  input  wire wb_req_t wb_req,
  output wb_rsp_t      wb_rsp
);

  // ------------------------------------------------------------
  // Internal nets
  // ------------------------------------------------------------

  // Group parities, bank to sampler
  osc_parity_t  parity;
  // Word, flag and count, sampler to registers
  sampler_out_t result;
  // Entropy read done, registers back to sampler
  logic         entropy_taken;

  // ------------------------------------------------------------
  // Blocks
  // ------------------------------------------------------------

  rosc_osc_bank rosc_osc_bank_i (
    .clk           (clk),
    .cycle_ctr_rst (cycle_ctr_rst),
    .parity        (parity)
  );

  rosc_sampler rosc_sampler_i (
    .clk           (clk),
    .cycle_ctr_rst (cycle_ctr_rst),
    .parity        (parity),
    .entropy_taken (entropy_taken),
    .result        (result)
  );

  rosc_wb_regs rosc_wb_regs_i (
    .clk           (clk),
    .cycle_ctr_rst (cycle_ctr_rst),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .result        (result),
    .entropy_taken (entropy_taken)
  );

endmodule

`default_nettype wire

//--- test/rosc_entropy_properties.sv
// Bus and ready-flag assertions, bound into the register block by the testbench
`timescale 1ns/10ps
`default_nettype none

module rosc_entropy_properties
  import rosc_wb_pkg::*;
(
  input wire          clk,
  input wire          cycle_ctr_rst,
  input wire wb_req_t wb_req,
  input wire wb_rsp_t wb_rsp,
  input wire          entropy_taken
);

  // ------------------------------------------------------------
  // Wishbone classic rules
  // ------------------------------------------------------------

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (
    @(posedge clk) disable iff (cycle_ctr_rst)
    wb_rsp.ack |=> !wb_rsp.ack
  ) else $error("ack stayed high for two cycles");

  // No ack without a strobe on the cycle before
  ack_after_stb: assert property (
    @(posedge clk) disable iff (cycle_ctr_rst)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)
  ) else $error("ack without a preceding cyc and stb");

  // ------------------------------------------------------------
  // Ready flag clear path
  // ------------------------------------------------------------

  taken_with_ack: assert property (
    @(posedge clk) disable iff (cycle_ctr_rst)
    entropy_taken |-> wb_rsp.ack
  ) else $error("entropy_taken pulsed outside an ack");

endmodule

`default_nettype wire

//--- test/rosc_entropy_tb.sv
// Directed testbench of the entropy source, top module of the simulation run
`timescale 1ns/10ps
`default_nettype none
`include "rosc_defines.svh"

module rosc_entropy_tb
  import rosc_wb_pkg::*;
();

  // ------------------------------------------------------------
  // Run limits and signals
  // ------------------------------------------------------------

  // One sampling round is two phases of rate+1 plus decide
  localparam longint round_cycles = 2 * longint'(`ROSC_SAMPLE_RATE) + 3;
  localparam longint limit_cycles = 40 * 32 * round_cycles + 2000;
  // Status polls take two cycles each
  localparam longint poll_limit   = 16 * 32 * round_cycles / 2;

  logic    clk;
  logic    cycle_ctr_rst;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  int      error_count;
  int      test_count;
  int      failed_tests;
  longint  cycles_since_reset;

  rosc_entropy_top rosc_entropy_top_i (
    .clk           (clk),
    .cycle_ctr_rst (cycle_ctr_rst),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp)
  );

  bind rosc_wb_regs rosc_entropy_properties rosc_entropy_properties_i (
    .clk           (clk),
    .cycle_ctr_rst (cycle_ctr_rst),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .entropy_taken (entropy_taken)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (cycle_ctr_rst) begin
      cycles_since_reset <= 0;
    end else begin
      cycles_since_reset <= cycles_since_reset + 1;
    end
  end

  // Watchdog
  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("Watchdog timeout, run exceeded %0d clock cycles", limit_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    error_count++;
    $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
  endtask

  task automatic finish_test(input string name, input int start_errors);
    test_count++;
    if (error_count != start_errors) begin
      failed_tests++;
      $display("Test %s: %0d errors", name, error_count - start_errors);
    end else begin
      $display("Test %s: ok", name);
    end
  endtask

  // True while no decide cycle can have kept a bit yet
  function automatic bit no_bit_kept_yet();
    return (cycles_since_reset + 8) < round_cycles;
  endfunction

  // Called on a falling edge with the request already driven
  task automatic wait_ack(output int ack_wait);
    ack_wait = 0;
    do begin
      @(negedge clk);
      ack_wait++;
    end while (!wb_rsp.ack && ack_wait < 4);
    if (!wb_rsp.ack) begin
      error_count++;
      $display("Bus access at address %h got no ack within 4 cycles", wb_req.adr);
    end
  endtask

  // One idle cycle first, so ack is expected one cycle after stb
  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat,
                         output int ack_wait);
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
    wait_ack(ack_wait);
    dat = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat,
                          output int ack_wait);
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    wait_ack(ack_wait);
    wb_req = '0;
  endtask

  task automatic wait_ready(output bit seen, output logic [31:0] status);
    int ack_wait;
    seen = 1'b0;
    for (longint i = 0; i < poll_limit && !seen; i++) begin
      wb_read(`ROSC_ADDR_STATUS, status, ack_wait);
      seen = status[0];
    end
    if (!seen) begin
      error_count++;
      $display("Ready flag never set while polling the status register");
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  task automatic test_reset_state();
    int          start_errors;
    int          ack_wait;
    bit          quiet;
    logic [31:0] dat;
    start_errors = error_count;
    quiet = no_bit_kept_yet();
    wb_read(`ROSC_ADDR_STATUS, dat, ack_wait);
    // Ready in bit 0, count in bits 5:1, rest reserved
    if (dat[0] !== 1'b0) report_mismatch("ready after reset", dat[0], 0);
    if (dat[31:6] !== 26'd0) report_mismatch("status reserved bits", dat[31:6], 0);
    if (quiet && dat[5:1] !== 5'd0) report_mismatch("bit_count after reset", dat[5:1], 0);
    wb_read(`ROSC_ADDR_ENTROPY, dat, ack_wait);
    if (quiet && dat !== 32'h0) report_mismatch("entropy after reset", dat, 0);
    finish_test("reset_state", start_errors);
  endtask

  task automatic test_bus_timing();
    int          start_errors;
    int          ack_wait;
    logic [7:0]  adr;
    logic [31:0] dat;
    start_errors = error_count;
    // stb held one cycle past ack, ack still drops
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: `ROSC_ADDR_STATUS, dat: 32'h0};
    @(negedge clk);
    if (wb_rsp.ack !== 1'b1) report_mismatch("ack one cycle after stb", wb_rsp.ack, 1);
    @(negedge clk);
    if (wb_rsp.ack !== 1'b0) report_mismatch("ack in its second cycle", wb_rsp.ack, 0);
    wb_req = '0;
    do begin
      adr = 8'($urandom);
    end while (adr == `ROSC_ADDR_STATUS || adr == `ROSC_ADDR_ENTROPY);
    wb_read(adr, dat, ack_wait);
    if (ack_wait != 1) report_mismatch("ack delay in cycles", ack_wait, 1);
    if (dat !== 32'h0) report_mismatch($sformatf("unmapped read at %h", adr), dat, 0);
    finish_test("bus_timing", start_errors);
  endtask

  task automatic test_writes_ignored();
    int          start_errors;
    int          ack_wait;
    bit          quiet;
    logic [31:0] dat;
    start_errors = error_count;
    quiet = no_bit_kept_yet();
    wb_write(`ROSC_ADDR_STATUS, $urandom, ack_wait);
    if (ack_wait != 1) report_mismatch("status write ack delay", ack_wait, 1);
    wb_write(`ROSC_ADDR_ENTROPY, $urandom, ack_wait);
    if (ack_wait != 1) report_mismatch("entropy write ack delay", ack_wait, 1);
    wb_read(`ROSC_ADDR_STATUS, dat, ack_wait);
    if (dat[0] !== 1'b0) report_mismatch("ready after writes", dat[0], 0);
    if (quiet && dat !== 32'h0) report_mismatch("status after writes", dat, 0);
    wb_read(`ROSC_ADDR_ENTROPY, dat, ack_wait);
    // Still before the first decide, so nothing shifted in
    if (quiet && dat !== 32'h0) report_mismatch("entropy after writes", dat, 0);
    finish_test("writes_ignored", start_errors);
  endtask

  task automatic test_ready_sets();
    int          start_errors;
    bit          seen;
    logic [31:0] status;
    start_errors = error_count;
    wait_ready(seen, status);
    if (seen) begin
      // Ready comes with the wrap of bit_count
      if (status[5:1] !== 5'd0) report_mismatch("bit_count at ready", status[5:1], 0);
      if (status[31:6] !== 26'd0) report_mismatch("status reserved bits", status[31:6], 0);
    end
    finish_test("ready_sets", start_errors);
  endtask

  task automatic test_entropy_clears();
    int          start_errors;
    int          ack_wait;
    bit          seen;
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] status;
    start_errors = error_count;
    wb_read(`ROSC_ADDR_ENTROPY, first, ack_wait);
    wb_read(`ROSC_ADDR_STATUS, status, ack_wait);
    if (status[0] !== 1'b0) report_mismatch("ready after entropy read", status[0], 0);
    wait_ready(seen, status);
    if (seen) begin
      wb_read(`ROSC_ADDR_ENTROPY, second, ack_wait);
      if (second === first) begin
        error_count++;
        $display("[FAIL] %0t ns: second entropy word %h repeats the first", $time, second);
      end
    end
    finish_test("entropy_clears", start_errors);
  endtask

  // ------------------------------------------------------------
  // Sequence
  // ------------------------------------------------------------

  initial begin
    cycle_ctr_rst      = 1'b1;
    wb_req             = '0;
    error_count        = 0;
    test_count         = 0;
    failed_tests       = 0;
    void'($urandom(32'he6c9));
    repeat (10) @(negedge clk);
    cycle_ctr_rst = 1'b0;
    test_reset_state();
    test_bus_timing();
    test_writes_ignored();
    test_ready_sets();
    test_entropy_clears();
    $display("Tests run %0d, tests failed %0d, errors %0d",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rosc_entropy.f
+incdir+include
source/rosc_wb_pkg.sv
source/rosc_entropy_pkg.sv
source/rosc_osc_bank.sv
source/rosc_sampler.sv
source/rosc_wb_regs.sv
source/rosc_entropy_top.sv
test/rosc_entropy_properties.sv
test/rosc_entropy_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the entropy source testbench with Verilator and runs it.
# Exit status is zero only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
obj_dir=obj_dir

if ! verilator --binary --timing --assert \
    -f rosc_entropy.f --top-module rosc_entropy_tb \
    --Mdir "$obj_dir" -o rosc_entropy_sim; then
  echo "Verilator build failed"
  exit 1
fi

"./$obj_dir/rosc_entropy_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" "$log_file"; then
  exit 0
fi

echo "Pass message not found in $log_file"
exit 1
